// File: tb.f
+incdir+tb
design/ib_pkg.sv
design/slot_store.sv
design/issue_select.sv
design/issue_port.sv
design/rob_rename_alloc.sv
design/instr_buffer_top.sv
tb/tb_top.sv

// File: Bender.yml
package:
  name: instr_buffer

sources:
  - files:
      - design/ib_pkg.sv
      - design/slot_store.sv
      - design/issue_select.sv
      - design/issue_port.sv
      - design/rob_rename_alloc.sv
      - design/instr_buffer_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_top.sv

// File: tb/ib_model.svh
`ifndef IB_MODEL_SVH
`define IB_MODEL_SVH

// buffered window, win[0] is the oldest instruction
instr_t      win [NUM_SLOTS];
instr_t      stream [$];
logic        m_valid;
int          m_hold_cnt;
logic        m_hold;
rob_idx_t    m_rob_head;
logic [31:0] rng_state;

// expected outputs of the current cycle
count_t      exp_count;
count_t      exp_num_fetch;
issue_t      exp_fxu0, exp_fxu1, exp_branch;
logic        exp_fxu0_b, exp_fxu1_b, exp_branch_b;
rob_alloc_t  exp_alloc [NUM_SLOTS];
rename_upd_t exp_upd [NUM_SLOTS];
int          n_fxu1, n_stall, n_flush, n_masked;

function automatic logic [31:0] xorshift();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

function automatic logic writes_reg(input opcode_t op);
    return op inside {4'd0, 4'd1, 4'd2, 4'd4, 4'd5, 4'd6};
endfunction

function automatic instr_t random_instr();
    instr_t ins;
    logic [31:0] r, s, t;
    r = xorshift();
    s = xorshift();
    t = xorshift();
    ins.opcode = r[3:0];
    ins.imm    = r[11:4];
    // narrow register range half the time so writers collide
    ins.rt     = r[12] ? r[16:13] : {2'b00, r[14:13]};
    case (r[19:17])
        3'd4, 3'd5: ins.unit = UNIT_BRANCH;
        3'd6:       ins.unit = UNIT_HALT;
        3'd7:       ins.unit = UNIT_NONE;
        default:    ins.unit = UNIT_FXU;
    endcase
    ins.uses_rb  = r[20];
    ins.ra.value = s[15:0];
    ins.ra.busy  = r[21];
    ins.ra.owner = r[25:22];
    ins.rb.value = s[31:16];
    ins.rb.busy  = r[26];
    ins.rb.owner = t[3:0];
    return ins;
endfunction

// register value, else forwarded from a finished ROB entry
task automatic resolve_operand(input operand_t op, output logic ok, output data_t val);
    ok  = !op.busy || rob_ready[op.owner];
    val = op.busy ? rob_values[op.owner] : op.value;
endtask

task automatic predict_issue(input logic g, input int pos, output issue_t r, output logic b_used);
    logic  ok;
    data_t val;
    r         = '0;
    r.valid   = g;
    r.rob_idx = m_rob_head + rob_idx_t'(pos);
    r.opcode  = win[pos].opcode;
    r.imm     = win[pos].imm;
    resolve_operand(win[pos].ra, ok, val);
    r.a_valid = ok;
    r.a_value = val;
    r.a_owner = win[pos].ra.owner;
    resolve_operand(win[pos].rb, ok, val);
    r.b_valid = ok || !win[pos].uses_rb;
    r.b_value = val;
    r.b_owner = win[pos].rb.owner;
    b_used    = win[pos].uses_rb;
endtask

task automatic model_eval();
    logic stop, g0, g1, gb, wr;
    int   p0, p1, pb;
    m_hold = flush || (m_hold_cnt != 0);
    stop   = !m_valid || m_hold;
    {g0, g1, gb} = 3'b000;
    {p0, p1, pb} = '0;
    exp_count = '0;
    for (int k = 0; k < NUM_SLOTS; k++) begin
        if (!stop && win[k].unit == UNIT_FXU) begin
            if (!fxu0_full && !g0) begin
                g0 = 1'b1;
                p0 = k;
            end else if (!fxu1_full && !g1) begin
                g1 = 1'b1;
                p1 = k;
            end else begin
                stop = 1'b1;
            end
        end else if (!stop && win[k].unit == UNIT_BRANCH) begin
            if (!branch_full && !gb) begin
                gb = 1'b1;
                pb = k;
            end else begin
                stop = 1'b1;
            end
        end
        if (!stop) begin
            exp_count = count_t'(k + 1);
        end
    end
    exp_num_fetch = (m_valid && !m_hold) ? exp_count : count_t'(NUM_SLOTS);
    predict_issue(g0, p0, exp_fxu0, exp_fxu0_b);
    predict_issue(g1, p1, exp_fxu1, exp_fxu1_b);
    predict_issue(gb, pb, exp_branch, exp_branch_b);
    for (int k = 0; k < NUM_SLOTS; k++) begin
        exp_alloc[k] = '0;
        exp_upd[k]   = '0;
        if (k < exp_count) begin
            exp_alloc[k].valid = 1'b1;
            exp_alloc[k].rt    = win[k].rt;
            exp_alloc[k].halt  = (win[k].unit == UNIT_HALT);
            wr = writes_reg(win[k].opcode);
            for (int j = k + 1; j < exp_count; j++) begin
                if (writes_reg(win[j].opcode) && win[j].rt == win[k].rt) begin
                    wr = 1'b0;
                end
            end
            if (writes_reg(win[k].opcode) && !wr) begin
                n_masked++;
            end
            exp_upd[k].enable = wr;
            exp_upd[k].target = win[k].rt;
            exp_upd[k].owner  = m_rob_head + rob_idx_t'(k);
        end
    end
    n_fxu1  += g1;
    n_flush += flush;
    if (m_valid && !m_hold && exp_count < NUM_SLOTS) begin
        n_stall++;
    end
endtask

// state after the clock edge
task automatic model_step();
    int n;
    n = exp_num_fetch;
    for (int i = 0; i < NUM_SLOTS - n; i++) begin
        win[i] = win[i + n];
    end
    for (int i = 0; i < n; i++) begin
        win[NUM_SLOTS - n + i] = stream.pop_front();
    end
    m_rob_head = m_rob_head + rob_idx_t'(exp_count);
    if (fetch_valid) begin
        m_valid = 1'b1;
    end
    if (flush) begin
        m_hold_cnt = FLUSH_CYCLES - 1;
    end else if (m_hold_cnt != 0) begin
        m_hold_cnt--;
    end
endtask

`endif

// File: tb/tb_top.sv
`timescale 1ns/100ps

module tb_top;
    import ib_pkg::*;

    localparam int FLUSH_CYCLES = 2;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 4;
    localparam int IDLE_CYCLES  = 4;
    localparam int FREE_CYCLES  = 80;
    localparam int NUM_CYCLES   = 1500;

    logic                   clk, rst_n, flush, fetch_valid;
    instr_t                 fetch_group [NUM_SLOTS];
    rob_idx_t               rob_head_idx;
    logic [ROB_ENTRIES-1:0] rob_ready;
    data_t                  rob_values [ROB_ENTRIES];
    logic                   fxu0_full, fxu1_full, branch_full;
    count_t                 num_fetch;
    issue_t                 fxu0_issue, fxu1_issue, branch_issue;
    rob_alloc_t             rob_alloc [NUM_SLOTS];
    rename_upd_t            rename_upd [NUM_SLOTS];

    `include "ib_model.svh"

    instr_buffer_top #(
        .FLUSH_CYCLES (FLUSH_CYCLES)
    ) u_instr_buffer_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .fetch_valid  (fetch_valid),
        .fetch_group  (fetch_group),
        .rob_head_idx (rob_head_idx),
        .rob_ready    (rob_ready),
        .rob_values   (rob_values),
        .fxu0_full    (fxu0_full),
        .fxu1_full    (fxu1_full),
        .branch_full  (branch_full),
        .num_fetch    (num_fetch),
        .fxu0_issue   (fxu0_issue),
        .fxu1_issue   (fxu1_issue),
        .branch_issue (branch_issue),
        .rob_alloc    (rob_alloc),
        .rename_upd   (rename_upd)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Fail at %0d ns: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("TEST FAIL");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    task automatic check_issue(input issue_t act, input issue_t exp, input logic b_used,
                               input string name);
        check_equal(act.valid, exp.valid, {name, ".valid"});
        if (exp.valid) begin
            check_equal(act.rob_idx, exp.rob_idx, {name, ".rob_idx"});
            check_equal(act.opcode, exp.opcode, {name, ".opcode"});
            check_equal(act.imm, exp.imm, {name, ".imm"});
            check_equal(act.a_valid, exp.a_valid, {name, ".a_valid"});
            if (exp.a_valid) begin
                check_equal(act.a_value, exp.a_value, {name, ".a_value"});
            end else begin
                check_equal(act.a_owner, exp.a_owner, {name, ".a_owner"});
            end
            check_equal(act.b_valid, exp.b_valid, {name, ".b_valid"});
            if (b_used && exp.b_valid) begin
                check_equal(act.b_value, exp.b_value, {name, ".b_value"});
            end else if (!exp.b_valid) begin
                check_equal(act.b_owner, exp.b_owner, {name, ".b_owner"});
            end
        end
    endtask

    task automatic check_outputs();
        check_equal(num_fetch, exp_num_fetch, "num_fetch");
        check_issue(fxu0_issue, exp_fxu0, exp_fxu0_b, "fxu0_issue");
        check_issue(fxu1_issue, exp_fxu1, exp_fxu1_b, "fxu1_issue");
        check_issue(branch_issue, exp_branch, exp_branch_b, "branch_issue");
        for (int k = 0; k < NUM_SLOTS; k++) begin
            check_equal(rob_alloc[k].valid, exp_alloc[k].valid, $sformatf("alloc %0d valid", k));
            check_equal(rob_alloc[k].halt, exp_alloc[k].halt, $sformatf("alloc %0d halt", k));
            if (exp_alloc[k].valid) begin
                check_equal(rob_alloc[k].rt, exp_alloc[k].rt, $sformatf("alloc %0d rt", k));
            end
            check_equal(rename_upd[k].enable, exp_upd[k].enable, $sformatf("rename %0d en", k));
            if (exp_upd[k].enable) begin
                check_equal(rename_upd[k].target, exp_upd[k].target, $sformatf("rename %0d rt", k));
                check_equal(rename_upd[k].owner, exp_upd[k].owner, $sformatf("rename %0d tag", k));
            end
        end
    endtask

    task automatic drive_inputs(input int cyc);
        logic [31:0] r;
        while (stream.size() < NUM_SLOTS) begin
            stream.push_back(random_instr());
        end
        for (int k = 0; k < NUM_SLOTS; k++) begin
            fetch_group[k] = stream[k];
        end
        fetch_valid = (cyc >= IDLE_CYCLES);
        r = xorshift();
        // units stay free early on, then random back-pressure and flushes
        fxu0_full   = (cyc >= FREE_CYCLES) && (r[1:0] == 2'b00);
        fxu1_full   = (cyc >= FREE_CYCLES) && (r[3:2] == 2'b00);
        branch_full = (cyc >= FREE_CYCLES) && (r[5:4] == 2'b00);
        flush       = (cyc >= FREE_CYCLES) && (r[10:6] == 5'd0);
        rob_ready   = r[31:16];
        for (int i = 0; i < ROB_ENTRIES; i++) begin
            r = xorshift();
            rob_values[i] = r[15:0];
        end
        rob_head_idx = m_rob_head;
    endtask

    initial begin
        rst_n = 1'b0;
        {flush, fetch_valid, fxu0_full, fxu1_full, branch_full} = '0;
        rob_head_idx = '0;
        rob_ready    = '0;
        for (int k = 0; k < NUM_SLOTS; k++) begin
            fetch_group[k] = '0;
        end
        for (int i = 0; i < ROB_ENTRIES; i++) begin
            rob_values[i] = '0;
        end
        rng_state  = 32'h8ff11d37;
        m_valid    = 1'b0;
        m_hold_cnt = 0;
        m_rob_head = '0;
        {n_fxu1, n_stall, n_flush, n_masked} = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            drive_inputs(cyc);
            model_eval();
            #5;
            check_outputs();
            model_step();
            @(posedge clk);
            #1;
        end
        check_equal(n_fxu1 > 0 && n_stall > 0 && n_flush > 0 && n_masked > 0, 1,
                    "coverage of dual FXU, stall, flush and rename masking");
        $display("TEST PASS");
        $finish;
    end

    initial begin
        #((NUM_CYCLES + RESET_CYCLES + 10) * CLK_PERIOD);
        $display("Timeout: the test did not finish within the expected number of cycles");
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: design/instr_buffer_top.sv
`timescale 1ns/100ps

module instr_buffer_top #(
    parameter int FLUSH_CYCLES = 2
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                flush,
    input  logic                                fetch_valid,
    input  ib_pkg::instr_t                      fetch_group [ib_pkg::NUM_SLOTS],
    input  ib_pkg::rob_idx_t                    rob_head_idx,
    input  logic [ib_pkg::ROB_ENTRIES-1:0]      rob_ready,
    input  ib_pkg::data_t                       rob_values [ib_pkg::ROB_ENTRIES],
    input  logic                                fxu0_full,
    input  logic                                fxu1_full,
    input  logic                                branch_full,
    output ib_pkg::count_t                      num_fetch,
    output ib_pkg::issue_t                      fxu0_issue,
    output ib_pkg::issue_t                      fxu1_issue,
    output ib_pkg::issue_t                      branch_issue,
    output ib_pkg::rob_alloc_t                  rob_alloc [ib_pkg::NUM_SLOTS],
    output ib_pkg::rename_upd_t                 rename_upd [ib_pkg::NUM_SLOTS]
);
    import ib_pkg::*;

    instr_t    ordered [NUM_SLOTS];
    logic      buf_valid;
    count_t    dispatch_count;
    logic      fxu0_grant;
    logic      fxu1_grant;
    logic      branch_grant;
    slot_idx_t fxu0_pos;
    slot_idx_t fxu1_pos;
    slot_idx_t branch_pos;

    // refill uses num_fetch, so a flush or cold start reloads every slot
    slot_store u_slot_store (
        .clk            (clk),
        .rst_n          (rst_n),
        .fetch_valid    (fetch_valid),
        .fetch_group    (fetch_group),
        .dispatch_count (num_fetch),
        .ordered        (ordered),
        .buf_valid      (buf_valid)
    );

    issue_select #(
        .FLUSH_CYCLES (FLUSH_CYCLES)
    ) u_issue_select (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .buf_valid      (buf_valid),
        .ordered        (ordered),
        .fxu0_full      (fxu0_full),
        .fxu1_full      (fxu1_full),
        .branch_full    (branch_full),
        .dispatch_count (dispatch_count),
        .num_fetch      (num_fetch),
        .fxu0_grant     (fxu0_grant),
        .fxu1_grant     (fxu1_grant),
        .branch_grant   (branch_grant),
        .fxu0_pos       (fxu0_pos),
        .fxu1_pos       (fxu1_pos),
        .branch_pos     (branch_pos)
    );

    issue_port u_fxu0_port (
        .grant        (fxu0_grant),
        .pos          (fxu0_pos),
        .ordered      (ordered),
        .rob_head_idx (rob_head_idx),
        .rob_ready    (rob_ready),
        .rob_values   (rob_values),
        .issue        (fxu0_issue)
    );

    issue_port u_fxu1_port (
        .grant        (fxu1_grant),
        .pos          (fxu1_pos),
        .ordered      (ordered),
        .rob_head_idx (rob_head_idx),
        .rob_ready    (rob_ready),
        .rob_values   (rob_values),
        .issue        (fxu1_issue)
    );

    issue_port u_branch_port (
        .grant        (branch_grant),
        .pos          (branch_pos),
        .ordered      (ordered),
        .rob_head_idx (rob_head_idx),
        .rob_ready    (rob_ready),
        .rob_values   (rob_values),
        .issue        (branch_issue)
    );

    rob_rename_alloc u_rob_rename_alloc (
        .ordered        (ordered),
        .buf_valid      (buf_valid),
        .dispatch_count (dispatch_count),
        .rob_head_idx   (rob_head_idx),
        .rob_alloc      (rob_alloc),
        .rename_upd     (rename_upd)
    );

endmodule

// File: design/rob_rename_alloc.sv
`timescale 1ns/100ps

module rob_rename_alloc (
    input  ib_pkg::instr_t      ordered [ib_pkg::NUM_SLOTS],
    input  logic                buf_valid,
    input  ib_pkg::count_t      dispatch_count,
    input  ib_pkg::rob_idx_t    rob_head_idx,
    output ib_pkg::rob_alloc_t  rob_alloc [ib_pkg::NUM_SLOTS],
    output ib_pkg::rename_upd_t rename_upd [ib_pkg::NUM_SLOTS]
);
    import ib_pkg::*;

    logic [NUM_SLOTS-1:0] dispatched;
    logic [NUM_SLOTS-1:0] writes;

    // dispatch is in order, so the first dispatch_count slots leave
    always_comb begin
        for (int k = 0; k < NUM_SLOTS; k++) begin
            dispatched[k] = buf_valid && (count_t'(k) < dispatch_count);
            writes[k]     = dispatched[k] && WRITES_REG_MASK[ordered[k].opcode];
        end
    end

    always_comb begin
        for (int k = 0; k < NUM_SLOTS; k++) begin
            rob_alloc[k].valid = dispatched[k];
            rob_alloc[k].rt    = ordered[k].rt;
            rob_alloc[k].halt  = dispatched[k] && (ordered[k].unit == UNIT_HALT);

            rename_upd[k].enable = writes[k];
            rename_upd[k].target = ordered[k].rt;
            rename_upd[k].owner  = rob_head_idx + rob_idx_t'(k);
            // youngest writer of a register wins
            for (int j = k + 1; j < NUM_SLOTS; j++) begin
                if (writes[j] && (ordered[j].rt == ordered[k].rt)) begin
                    rename_upd[k].enable = 1'b0;
                end
            end
        end
    end

endmodule

// File: design/issue_port.sv
`timescale 1ns/100ps

module issue_port (
    input  logic                           grant,
    input  ib_pkg::slot_idx_t              pos,
    input  ib_pkg::instr_t                 ordered [ib_pkg::NUM_SLOTS],
    input  ib_pkg::rob_idx_t               rob_head_idx,
    input  logic [ib_pkg::ROB_ENTRIES-1:0] rob_ready,
    input  ib_pkg::data_t                  rob_values [ib_pkg::ROB_ENTRIES],
    output ib_pkg::issue_t                 issue
);
    import ib_pkg::*;

    instr_t sel;
    logic   a_fwd_ready;
    logic   b_fwd_ready;

    assign sel = ordered[pos];

    // owner already finished in the ROB
    assign a_fwd_ready = rob_ready[sel.ra.owner];
    assign b_fwd_ready = rob_ready[sel.rb.owner];

    always_comb begin
        issue.valid   = grant;
        // ROB entries are handed out in buffer order from the ROB head
        issue.rob_idx = rob_head_idx + rob_idx_t'(pos);
        issue.opcode  = sel.opcode;
        issue.imm     = sel.imm;

        issue.a_valid = !sel.ra.busy || a_fwd_ready;
        issue.a_value = sel.ra.busy ? rob_values[sel.ra.owner] : sel.ra.value;
        issue.a_owner = sel.ra.owner;

        // b is don't-care for one-source instructions
        issue.b_valid = !sel.uses_rb || !sel.rb.busy || b_fwd_ready;
        issue.b_value = sel.rb.busy ? rob_values[sel.rb.owner] : sel.rb.value;
        issue.b_owner = sel.rb.owner;
    end

endmodule

// File: design/issue_select.sv
`timescale 1ns/100ps

module issue_select #(
    parameter int FLUSH_CYCLES = 2
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  logic              buf_valid,
    input  ib_pkg::instr_t    ordered [ib_pkg::NUM_SLOTS],
    input  logic              fxu0_full,
    input  logic              fxu1_full,
    input  logic              branch_full,
    output ib_pkg::count_t    dispatch_count,
    output ib_pkg::count_t    num_fetch,
    output logic              fxu0_grant,
    output logic              fxu1_grant,
    output logic              branch_grant,
    output ib_pkg::slot_idx_t fxu0_pos,
    output ib_pkg::slot_idx_t fxu1_pos,
    output ib_pkg::slot_idx_t branch_pos
);
    import ib_pkg::*;

    localparam int HOLD_W = $clog2(FLUSH_CYCLES + 1);

    logic [HOLD_W-1:0] hold_cnt;
    logic              hold;
    logic              stalled;
    logic              any_grant;

    // flush cycle itself plus FLUSH_CYCLES-1 more
    assign hold = flush || (hold_cnt != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_cnt <= '0;
        end else if (flush) begin
            hold_cnt <= HOLD_W'(FLUSH_CYCLES - 1);
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    // oldest first, first slot without a port ends the cycle
    always_comb begin
        stalled        = !buf_valid || hold;
        fxu0_grant     = 1'b0;
        fxu1_grant     = 1'b0;
        branch_grant   = 1'b0;
        fxu0_pos       = '0;
        fxu1_pos       = '0;
        branch_pos     = '0;
        dispatch_count = '0;
        for (int k = 0; k < NUM_SLOTS; k++) begin
            if (!stalled) begin
                case (ordered[k].unit)
                    UNIT_FXU: begin
                        if (!fxu0_full && !fxu0_grant) begin
                            fxu0_grant = 1'b1;
                            fxu0_pos   = slot_idx_t'(k);
                        end else if (!fxu1_full && !fxu1_grant) begin
                            fxu1_grant = 1'b1;
                            fxu1_pos   = slot_idx_t'(k);
                        end else begin
                            stalled = 1'b1;
                        end
                    end
                    UNIT_BRANCH: begin
                        if (!branch_full && !branch_grant) begin
                            branch_grant = 1'b1;
                            branch_pos   = slot_idx_t'(k);
                        end else begin
                            stalled = 1'b1;
                        end
                    end
                    // halts and unitless instructions just retire into the ROB
                    default: begin
                    end
                endcase
                if (!stalled) begin
                    dispatch_count = count_t'(k + 1);
                end
            end
        end
    end

    assign num_fetch = (buf_valid && !hold) ? dispatch_count : count_t'(NUM_SLOTS);
    assign any_grant = fxu0_grant || fxu1_grant || branch_grant;

    fxu_pos_distinct_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        (fxu0_grant && fxu1_grant) |-> (fxu0_pos != fxu1_pos)
    );

    // whole hold window after a flush pulse is silent
    flush_quiet_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        flush |-> !any_grant [*FLUSH_CYCLES]
    );

endmodule

// File: design/slot_store.sv
`timescale 1ns/100ps

module slot_store (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           fetch_valid,
    input  ib_pkg::instr_t fetch_group [ib_pkg::NUM_SLOTS],
    input  ib_pkg::count_t dispatch_count,
    output ib_pkg::instr_t ordered [ib_pkg::NUM_SLOTS],
    output logic           buf_valid
);
    import ib_pkg::*;

    instr_t    slots [NUM_SLOTS];
    slot_idx_t head;

    // ring view, oldest first
    always_comb begin
        for (int k = 0; k < NUM_SLOTS; k++) begin
            ordered[k] = slots[head + slot_idx_t'(k)];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head      <= '0;
            buf_valid <= 1'b0;
        end else begin
            if (fetch_valid) begin
                buf_valid <= 1'b1;
            end
            // a count of 4 wraps back onto the same head
            if (buf_valid) begin
                head <= head + slot_idx_t'(dispatch_count);
            end
        end
    end

    // freed positions sit at head .. head+count-1, behind the stalled ones
    always_ff @(posedge clk) begin
        for (int k = 0; k < NUM_SLOTS; k++) begin
            if (!buf_valid) begin
                slots[k] <= fetch_group[k];
            end else if (count_t'(k) < dispatch_count) begin
                slots[head + slot_idx_t'(k)] <= fetch_group[k];
            end
        end
    end

    // cold load must land with the oldest instruction at slot 0
    head_still_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        !buf_valid |=> $stable(head)
    );

endmodule

// File: design/ib_pkg.sv
package ib_pkg;

    localparam int NUM_SLOTS   = 4;
    localparam int ROB_ENTRIES = 16;

    typedef logic [15:0] data_t;
    typedef logic [3:0]  reg_idx_t;
    typedef logic [3:0]  rob_idx_t;
    typedef logic [3:0]  opcode_t;
    typedef logic [7:0]  imm_t;
    typedef logic [1:0]  slot_idx_t;
    typedef logic [2:0]  count_t;

    // execution unit an instruction needs
    typedef enum logic [1:0] {
        UNIT_NONE,
        UNIT_FXU,
        UNIT_BRANCH,
        UNIT_HALT
    } unit_e;

    // bit n set when opcode n writes rt (0, 1, 2, 4, 5, 6)
    localparam logic [15:0] WRITES_REG_MASK = 16'h0077;

    // register file read result for one source
    typedef struct packed {
        data_t    value;
        logic     busy;
        rob_idx_t owner;
    } operand_t;

    typedef struct packed {
        opcode_t  opcode;
        imm_t     imm;
        reg_idx_t rt;
        logic     uses_rb;
        unit_e    unit;
        operand_t ra;
        operand_t rb;
    } instr_t;

    // one issue port toward an execution unit
    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
        opcode_t  opcode;
        imm_t     imm;
        logic     a_valid;
        data_t    a_value;
        rob_idx_t a_owner;
        logic     b_valid;
        data_t    b_value;
        rob_idx_t b_owner;
    } issue_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rt;
        logic     halt;
    } rob_alloc_t;

    typedef struct packed {
        logic     enable;
        reg_idx_t target;
        rob_idx_t owner;
    } rename_upd_t;

endpackage
